// ==== cpu_pkg.sv ====
package cpu_pkg;

  localparam int XLEN       = 32;
  localparam int IMEM_WORDS = 64;
  localparam int DMEM_WORDS = 64;
  localparam int REG_ID_W   = 5;
  localparam int IMEM_AW    = $clog2(IMEM_WORDS);
  localparam int DMEM_AW    = $clog2(DMEM_WORDS);

  localparam logic [6:0] OP_R      = 7'b0110011;
  localparam logic [6:0] OP_I      = 7'b0010011;
  localparam logic [6:0] OP_LOAD   = 7'b0000011;
  localparam logic [6:0] OP_STORE  = 7'b0100011;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_JAL    = 7'b1101111;

  typedef logic [31:0] instr_t;

  // add is zero so a cleared control is a plain nop
  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT
  } alu_op_e;

  typedef struct packed {
    logic                reg_write;
    logic                mem_read;
    logic                mem_write;
    logic                branch;
    logic                branch_ne;
    logic                jump;
    logic                alu_src_imm;
    alu_op_e             alu_op;
    logic [REG_ID_W-1:0] rd;
  } control_t;

  typedef struct packed {
    logic [XLEN-1:0] pc;
    instr_t          instr;
  } if_id_t;

  typedef struct packed {
    logic [XLEN-1:0]     pc;
    logic [XLEN-1:0]     read1;
    logic [XLEN-1:0]     read2;
    logic [XLEN-1:0]     imm;
    logic [REG_ID_W-1:0] rs1;
    logic [REG_ID_W-1:0] rs2;
    control_t            ctrl;
  } id_ex_t;

  typedef struct packed {
    logic [XLEN-1:0] alu_res;
    logic [XLEN-1:0] store_data;
    control_t        ctrl;
  } ex_mem_t;

  typedef struct packed {
    logic [XLEN-1:0] wb_data;
    control_t        ctrl;
  } mem_wb_t;

  typedef struct packed {
    logic                valid;
    logic [REG_ID_W-1:0] rd;
    logic [XLEN-1:0]     data;
  } commit_t;

endpackage

// ==== cpu_top.sv ====
module cpu_top (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        load_valid,
  input  logic [cpu_pkg::IMEM_AW-1:0] load_addr,
  input  logic [cpu_pkg::XLEN-1:0]    load_data,
  input  logic                        start,
  output cpu_pkg::commit_t            commit
);

  import cpu_pkg::*;

  if_id_t          if_id_d, if_id_q;
  id_ex_t          id_ex_d, id_ex_q;
  ex_mem_t         ex_mem_d, ex_mem_q;
  mem_wb_t         mem_wb_d, mem_wb_q;
  logic            stall;
  logic            redirect;
  logic [XLEN-1:0] redirect_pc;
  logic [XLEN-1:0] fwd1, fwd2;
  logic            fwd1_sel, fwd2_sel;

  fetch_stage i_fetch (
    .clk(clk), .rst(rst), .start(start),
    .load_valid(load_valid), .load_addr(load_addr), .load_data(load_data),
    .stall(stall), .redirect(redirect), .redirect_pc(redirect_pc),
    .out(if_id_d)
  );

  pipe_reg #(.payload_t(if_id_t)) i_if_id (
    .clk(clk), .rst(rst), .hold(stall), .flush(redirect), .d(if_id_d), .q(if_id_q)
  );

  decode_stage i_decode (
    .clk(clk), .rst(rst), .in(if_id_q), .wb(mem_wb_q), .out(id_ex_d)
  );

  // stores and register forms read rs2
  hazard_unit i_hazard (
    .id_rs1(id_ex_d.rs1), .id_rs2(id_ex_d.rs2),
    .id_uses_rs2(!id_ex_d.ctrl.alu_src_imm || id_ex_d.ctrl.mem_write),
    .ex_ctrl(id_ex_q.ctrl), .stall(stall)
  );

  pipe_reg #(.payload_t(id_ex_t)) i_id_ex (
    .clk(clk), .rst(rst), .hold(1'b0), .flush(redirect || stall),
    .d(id_ex_d), .q(id_ex_q)
  );

  forwarding_unit i_fwd (
    .ex_rs1(id_ex_q.rs1), .ex_rs2(id_ex_q.rs2),
    .mem_stage(ex_mem_q), .wb_stage(mem_wb_q),
    .fwd1(fwd1), .fwd2(fwd2), .fwd1_sel(fwd1_sel), .fwd2_sel(fwd2_sel)
  );

  execute_stage i_execute (
    .in(id_ex_q), .fwd1(fwd1), .fwd2(fwd2), .fwd1_sel(fwd1_sel), .fwd2_sel(fwd2_sel),
    .out(ex_mem_d), .redirect(redirect), .redirect_pc(redirect_pc)
  );

  pipe_reg #(.payload_t(ex_mem_t)) i_ex_mem (
    .clk(clk), .rst(rst), .hold(1'b0), .flush(1'b0), .d(ex_mem_d), .q(ex_mem_q)
  );

  memory_stage i_memory (
    .clk(clk), .in(ex_mem_q), .out(mem_wb_d)
  );

  pipe_reg #(.payload_t(mem_wb_t)) i_mem_wb (
    .clk(clk), .rst(rst), .hold(1'b0), .flush(1'b0), .d(mem_wb_d), .q(mem_wb_q)
  );

  assign commit.valid = mem_wb_q.ctrl.reg_write;
  assign commit.rd    = mem_wb_q.ctrl.rd;
  assign commit.data  = mem_wb_q.wb_data;

endmodule

// ==== decode_stage.sv ====
module decode_stage (
  input  logic             clk,
  input  logic             rst,
  input  cpu_pkg::if_id_t  in,
  input  cpu_pkg::mem_wb_t wb,
  output cpu_pkg::id_ex_t  out
);

  import cpu_pkg::*;

  logic [XLEN-1:0]     regs [32];
  logic [6:0]          opcode;
  logic [2:0]          funct3;
  logic [6:0]          funct7;
  logic [REG_ID_W-1:0] rs1;
  logic [REG_ID_W-1:0] rs2;
  logic [XLEN-1:0]     imm_i, imm_s, imm_b, imm_j;
  logic [XLEN-1:0]     read1;
  logic [XLEN-1:0]     read2;
  logic [XLEN-1:0]     imm;
  control_t            ctrl;

  assign opcode = in.instr[6:0];
  assign funct3 = in.instr[14:12];
  assign funct7 = in.instr[31:25];

  assign imm_i = {{20{in.instr[31]}}, in.instr[31:20]};
  assign imm_s = {{20{in.instr[31]}}, in.instr[31:25], in.instr[11:7]};
  assign imm_b = {{19{in.instr[31]}}, in.instr[31], in.instr[7], in.instr[30:25],
                  in.instr[11:8], 1'b0};
  assign imm_j = {{11{in.instr[31]}}, in.instr[31], in.instr[19:12], in.instr[20],
                  in.instr[30:21], 1'b0};

  always_comb begin
    ctrl = '0;
    case (opcode)
      OP_R: begin
        ctrl.reg_write = 1'b1;
        case (funct3)
          3'b000:  ctrl.alu_op = funct7[5] ? ALU_SUB : ALU_ADD;
          3'b111:  ctrl.alu_op = ALU_AND;
          3'b110:  ctrl.alu_op = ALU_OR;
          3'b100:  ctrl.alu_op = ALU_XOR;
          3'b010:  ctrl.alu_op = ALU_SLT;
          default: ctrl.reg_write = 1'b0;
        endcase
      end
      OP_I: begin
        ctrl.reg_write   = (funct3 == 3'b000); // addi only
        ctrl.alu_src_imm = (funct3 == 3'b000);
      end
      OP_LOAD: begin
        ctrl.reg_write   = (funct3 == 3'b010);
        ctrl.mem_read    = (funct3 == 3'b010);
        ctrl.alu_src_imm = (funct3 == 3'b010);
      end
      OP_STORE: begin
        ctrl.mem_write   = (funct3 == 3'b010);
        ctrl.alu_src_imm = (funct3 == 3'b010);
      end
      OP_BRANCH: begin
        ctrl.branch    = (funct3 == 3'b000) || (funct3 == 3'b001);
        ctrl.branch_ne = (funct3 == 3'b001);
      end
      OP_JAL: begin
        ctrl.reg_write   = 1'b1;
        ctrl.jump        = 1'b1;
        ctrl.alu_src_imm = 1'b1; // no rs2
      end
      default: ctrl = '0;
    endcase
    // x0 destinations never retire
    if (in.instr[11:7] == '0) begin
      ctrl.reg_write = 1'b0;
    end
    ctrl.rd = ctrl.reg_write ? in.instr[11:7] : '0;
  end

  // jal has immediate bits where rs1 would be
  assign rs1 = ctrl.jump ? '0 : in.instr[19:15];
  assign rs2 = in.instr[24:20];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wb.ctrl.reg_write && wb.ctrl.rd != '0) begin
      regs[wb.ctrl.rd] <= wb.wb_data;
    end
  end

  // write-through read
  function automatic logic [XLEN-1:0] read_reg(input logic [REG_ID_W-1:0] idx);
    if (idx == '0) begin
      return '0;
    end
    if (wb.ctrl.reg_write && wb.ctrl.rd == idx) begin
      return wb.wb_data;
    end
    return regs[idx];
  endfunction

  always_comb begin
    read1 = read_reg(rs1);
    read2 = read_reg(rs2);
  end

  always_comb begin
    case (opcode)
      OP_STORE:  imm = imm_s;
      OP_BRANCH: imm = imm_b;
      OP_JAL:    imm = imm_j;
      default:   imm = imm_i;
    endcase
  end

  assign out.pc    = in.pc;
  assign out.read1 = read1;
  assign out.read2 = read2;
  assign out.imm   = imm;
  assign out.rs1   = rs1;
  assign out.rs2   = rs2;
  assign out.ctrl  = ctrl;

  // a write request arriving from writeback never names x0
  wb_no_x0: assert property (
    @(posedge clk) disable iff (rst) wb.ctrl.reg_write |-> (wb.ctrl.rd != '0)
  ) else $error("decode: register write to x0 reached writeback");

endmodule

// ==== execute_stage.sv ====
module execute_stage (
  input  cpu_pkg::id_ex_t          in,
  input  logic [cpu_pkg::XLEN-1:0] fwd1,
  input  logic [cpu_pkg::XLEN-1:0] fwd2,
  input  logic                     fwd1_sel,
  input  logic                     fwd2_sel,
  output cpu_pkg::ex_mem_t         out,
  output logic                     redirect,
  output logic [cpu_pkg::XLEN-1:0] redirect_pc
);

  import cpu_pkg::*;

  logic [XLEN-1:0] op1;
  logic [XLEN-1:0] op2_reg;
  logic [XLEN-1:0] op2;
  logic [XLEN-1:0] alu_y;
  logic            equal;
  logic            taken;

  assign op1     = fwd1_sel ? fwd1 : in.read1;
  assign op2_reg = fwd2_sel ? fwd2 : in.read2;
  assign op2     = in.ctrl.alu_src_imm ? in.imm : op2_reg;

  always_comb begin
    case (in.ctrl.alu_op)
      ALU_SUB: alu_y = op1 - op2;
      ALU_AND: alu_y = op1 & op2;
      ALU_OR:  alu_y = op1 | op2;
      ALU_XOR: alu_y = op1 ^ op2;
      ALU_SLT: alu_y = {{(XLEN-1){1'b0}}, $signed(op1) < $signed(op2)};
      default: alu_y = op1 + op2;
    endcase
  end

  assign equal = (op1 == op2_reg);
  assign taken = in.ctrl.branch && (in.ctrl.branch_ne ? !equal : equal);

  assign redirect    = taken || in.ctrl.jump;
  assign redirect_pc = in.pc + in.imm;

  assign out.alu_res    = in.ctrl.jump ? in.pc + XLEN'(4) : alu_y; // link value
  assign out.store_data = op2_reg;
  assign out.ctrl       = in.ctrl;

  // branch and jump immediates from decode keep targets word aligned
  always_comb begin
    if (redirect) begin
      assert ((in.ctrl.branch || in.ctrl.jump) && redirect_pc[1:0] == 2'b00)
      else $error("execute: redirect without branch or to unaligned target");
    end
  end

endmodule

// ==== fetch_stage.sv ====
module fetch_stage (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       start,
  input  logic                       load_valid,
  input  logic [cpu_pkg::IMEM_AW-1:0] load_addr,
  input  logic [cpu_pkg::XLEN-1:0]   load_data,
  input  logic                       stall,
  input  logic                       redirect,
  input  logic [cpu_pkg::XLEN-1:0]   redirect_pc,
  output cpu_pkg::if_id_t            out
);

  import cpu_pkg::*;

  instr_t          imem [IMEM_WORDS];
  logic            run;
  logic [XLEN-1:0] pc;

  always_ff @(posedge clk) begin
    if (load_valid) begin
      imem[load_addr] <= load_data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      run <= 1'b0;
      pc  <= '0;
    end else if (start) begin
      run <= 1'b1;
      pc  <= '0;
    end else if (run && redirect) begin
      pc <= redirect_pc; // flush beats stall
    end else if (run && !stall) begin
      pc <= pc + XLEN'(4);
    end
  end

  assign out.pc    = pc;
  assign out.instr = run ? imem[pc[IMEM_AW+1:2]] : '0; // zero word decodes as nop

  no_load_while_running: assert property (
    @(posedge clk) disable iff (rst) run |-> !load_valid
  ) else $error("fetch: instruction load while program runs");

endmodule

// ==== forwarding_unit.sv ====
module forwarding_unit (
  input  logic [cpu_pkg::REG_ID_W-1:0] ex_rs1,
  input  logic [cpu_pkg::REG_ID_W-1:0] ex_rs2,
  input  cpu_pkg::ex_mem_t             mem_stage,
  input  cpu_pkg::mem_wb_t             wb_stage,
  output logic [cpu_pkg::XLEN-1:0]     fwd1,
  output logic [cpu_pkg::XLEN-1:0]     fwd2,
  output logic                         fwd1_sel,
  output logic                         fwd2_sel
);

  logic mem_ok, wb_ok;
  logic mem1, mem2;
  logic wb1, wb2;

  assign mem_ok = mem_stage.ctrl.reg_write && (mem_stage.ctrl.rd != '0);
  assign wb_ok  = wb_stage.ctrl.reg_write && (wb_stage.ctrl.rd != '0);

  assign mem1 = mem_ok && (mem_stage.ctrl.rd == ex_rs1);
  assign mem2 = mem_ok && (mem_stage.ctrl.rd == ex_rs2);
  assign wb1  = wb_ok && (wb_stage.ctrl.rd == ex_rs1);
  assign wb2  = wb_ok && (wb_stage.ctrl.rd == ex_rs2);

  // youngest producer first
  assign fwd1_sel = mem1 || wb1;
  assign fwd2_sel = mem2 || wb2;
  assign fwd1     = mem1 ? mem_stage.alu_res : wb_stage.wb_data;
  assign fwd2     = mem2 ? mem_stage.alu_res : wb_stage.wb_data;

endmodule

// ==== hazard_unit.sv ====
module hazard_unit (
  input  logic [cpu_pkg::REG_ID_W-1:0] id_rs1,
  input  logic [cpu_pkg::REG_ID_W-1:0] id_rs2,
  input  logic                         id_uses_rs2,
  input  cpu_pkg::control_t            ex_ctrl,
  output logic                         stall
);

  logic load_in_ex;
  logic hit_rs1;
  logic hit_rs2;

  assign load_in_ex = ex_ctrl.mem_read && (ex_ctrl.rd != '0);

  // rs1 is zeroed by decode when the field is an immediate
  assign hit_rs1 = (ex_ctrl.rd == id_rs1);
  assign hit_rs2 = id_uses_rs2 && (ex_ctrl.rd == id_rs2);

  assign stall = load_in_ex && (hit_rs1 || hit_rs2);

endmodule

// ==== memory_stage.sv ====
module memory_stage (
  input  logic             clk,
  input  cpu_pkg::ex_mem_t in,
  output cpu_pkg::mem_wb_t out
);

  import cpu_pkg::*;

  logic [XLEN-1:0]    dmem [DMEM_WORDS];
  logic [DMEM_AW-1:0] word_addr;

  assign word_addr = in.alu_res[DMEM_AW+1:2];

  always_ff @(posedge clk) begin
    if (in.ctrl.mem_write) begin
      dmem[word_addr] <= in.store_data;
    end
  end

  // writeback select lives here
  assign out.wb_data = in.ctrl.mem_read ? dmem[word_addr] : in.alu_res;
  assign out.ctrl    = in.ctrl;

  no_read_and_write: assert property (
    @(posedge clk) in.ctrl.mem_read |-> !in.ctrl.mem_write
  ) else $error("memory: load and store in the same slot");

endmodule

// ==== pipe_reg.sv ====
module pipe_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     hold,
  input  logic     flush,
  input  payload_t d,
  output payload_t q
);

  always_ff @(posedge clk) begin
    if (rst || flush) begin
      q <= '0; // bubble
    end else if (!hold) begin
      q <= d;
    end
  end

  // a flushed slot must reach the next stage as a bubble
  flush_clears: assert property (
    @(posedge clk) disable iff (rst) flush |=> (q == '0)
  ) else $error("pipe_reg: payload not cleared after flush");

endmodule

// ==== sim.f ====
cpu_pkg.sv
pipe_reg.sv
fetch_stage.sv
decode_stage.sv
hazard_unit.sv
forwarding_unit.sv
execute_stage.sv
memory_stage.sv
cpu_top.sv
tb_cpu.sv

// ==== tb_cpu.sv ====
module tb_cpu;

  import cpu_pkg::*;

  localparam int N_TESTS   = 5;
  localparam int MAX_INSTR = 16;
  localparam int MAX_EXP   = 12;
  localparam int MAX_CYCLES = 200 * N_TESTS;

  logic                clk;
  logic                rst;
  logic                load_valid;
  logic [IMEM_AW-1:0]  load_addr;
  logic [XLEN-1:0]     load_data;
  logic                start;
  commit_t             commit;

  logic [31:0] prog     [N_TESTS][MAX_INSTR];
  int          prog_len [N_TESTS];
  logic [4:0]  exp_rd   [N_TESTS][MAX_EXP];
  logic [31:0] exp_data [N_TESTS][MAX_EXP];
  int          exp_len  [N_TESTS];

  integer seed = 57293;
  int     cycles;
  int     cur;
  int     got_count;
  int     test_errors;
  int     total_errors;
  int     failed_tests;
  logic   started;

  cpu_top i_dut (
    .clk(clk), .rst(rst), .load_valid(load_valid), .load_addr(load_addr),
    .load_data(load_data), .start(start), .commit(commit)
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: run still busy after %0d cycles", cycles);
      $display("** FAIL **");
      $finish;
    end
  end

  // small assembler for the supported subset
  function automatic logic [31:0] addi(input int rd, input int rs1, input logic [31:0] imm);
    return {imm[11:0], 5'(rs1), 3'b000, 5'(rd), OP_I};
  endfunction

  function automatic logic [31:0] r_op(input logic [2:0] f3, input logic [6:0] f7,
                                       input int rd, input int rs1, input int rs2);
    return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), OP_R};
  endfunction

  function automatic logic [31:0] lw(input int rd, input int rs1, input logic [31:0] imm);
    return {imm[11:0], 5'(rs1), 3'b010, 5'(rd), OP_LOAD};
  endfunction

  function automatic logic [31:0] sw(input int rs2, input int rs1, input logic [31:0] imm);
    return {imm[11:5], 5'(rs2), 5'(rs1), 3'b010, imm[4:0], OP_STORE};
  endfunction

  function automatic logic [31:0] branch(input logic [2:0] f3, input int rs1, input int rs2,
                                         input logic [31:0] imm);
    return {imm[12], imm[10:5], 5'(rs2), 5'(rs1), f3, imm[4:1], imm[11], OP_BRANCH};
  endfunction

  function automatic logic [31:0] jal(input int rd, input logic [31:0] imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], 5'(rd), OP_JAL};
  endfunction

  task automatic put_instr(input int t, input logic [31:0] w);
    prog[t][prog_len[t]] = w;
    prog_len[t]++;
  endtask

  task automatic put_commit(input int t, input int rd, input logic [31:0] data);
    exp_rd[t][exp_len[t]]   = 5'(rd);
    exp_data[t][exp_len[t]] = data;
    exp_len[t]++;
  endtask

  task automatic build_table();
    logic [31:0] a;
    logic [31:0] b;
    a = $random(seed) & 32'h0000_07ff;          // non-negative
    b = ($random(seed) & 32'h0000_07ff) | 32'hffff_f800; // negative
    for (int t = 0; t < N_TESTS; t++) begin
      prog_len[t] = 0;
      exp_len[t]  = 0;
    end
    // alu ops
    put_instr(0, addi(1, 0, a));
    put_commit(0, 1, a);
    put_instr(0, addi(2, 0, b));
    put_commit(0, 2, b);
    put_instr(0, r_op(3'b000, 7'h00, 3, 1, 2));
    put_commit(0, 3, a + b);
    put_instr(0, r_op(3'b000, 7'h20, 4, 1, 2));
    put_commit(0, 4, a - b);
    put_instr(0, r_op(3'b111, 7'h00, 5, 1, 2));
    put_commit(0, 5, a & b);
    put_instr(0, r_op(3'b110, 7'h00, 6, 1, 2));
    put_commit(0, 6, a | b);
    put_instr(0, r_op(3'b100, 7'h00, 7, 1, 2));
    put_commit(0, 7, a ^ b);
    put_instr(0, r_op(3'b010, 7'h00, 8, 1, 2));
    put_commit(0, 8, 32'd0);
    put_instr(0, r_op(3'b010, 7'h00, 9, 2, 1));
    put_commit(0, 9, 32'd1); // negative < positive
    put_instr(0, jal(0, 0));
    // dependency chains
    put_instr(1, addi(1, 0, 5));
    put_commit(1, 1, 32'd5);
    put_instr(1, addi(2, 1, 3));
    put_commit(1, 2, 32'd8);
    put_instr(1, addi(3, 1, 10));
    put_commit(1, 3, 32'd15);
    put_instr(1, r_op(3'b000, 7'h00, 4, 2, 3));
    put_commit(1, 4, 32'd23);
    put_instr(1, addi(0, 4, 7));      // x0 target, no commit
    put_instr(1, r_op(3'b000, 7'h00, 5, 0, 4));
    put_commit(1, 5, 32'd23);
    put_instr(1, r_op(3'b000, 7'h00, 6, 5, 5));
    put_commit(1, 6, 32'd46);
    put_instr(1, r_op(3'b000, 7'h00, 7, 1, 4));
    put_commit(1, 7, 32'd28);
    put_instr(1, jal(0, 0));
    // stores, loads, load-use
    put_instr(2, addi(1, 0, 100));
    put_commit(2, 1, 32'd100);
    put_instr(2, addi(2, 0, -7));
    put_commit(2, 2, -32'sd7);
    put_instr(2, sw(2, 1, 8));
    put_instr(2, sw(1, 1, 12));
    put_instr(2, lw(3, 1, 8));
    put_commit(2, 3, -32'sd7);
    put_instr(2, lw(4, 1, 12));
    put_commit(2, 4, 32'd100);
    put_instr(2, r_op(3'b000, 7'h00, 5, 4, 3));
    put_commit(2, 5, 32'd93);
    put_instr(2, lw(6, 1, 8));
    put_commit(2, 6, -32'sd7);
    put_instr(2, r_op(3'b000, 7'h20, 7, 0, 6));
    put_commit(2, 7, 32'd7);
    put_instr(2, jal(0, 0));
    // branches
    put_instr(3, addi(1, 0, 1));
    put_commit(3, 1, 32'd1);
    put_instr(3, addi(2, 0, 1));
    put_commit(3, 2, 32'd1);
    put_instr(3, branch(3'b000, 1, 2, 12)); // beq taken to 20
    put_instr(3, addi(3, 0, 99));
    put_instr(3, addi(4, 0, 99));
    put_instr(3, addi(5, 0, 2));
    put_commit(3, 5, 32'd2);
    put_instr(3, branch(3'b001, 1, 5, 12)); // bne taken to 36
    put_instr(3, addi(6, 0, 99));
    put_instr(3, addi(7, 0, 99));
    put_instr(3, branch(3'b000, 1, 5, 8)); // falls through
    put_instr(3, addi(8, 0, 3));
    put_commit(3, 8, 32'd3);
    put_instr(3, jal(0, 0));
    // jumps with link
    put_instr(4, addi(1, 0, 4));
    put_commit(4, 1, 32'd4);
    put_instr(4, jal(2, 12));
    put_commit(4, 2, 32'd8);
    put_instr(4, addi(3, 0, 99));
    put_instr(4, addi(3, 0, 98));
    put_instr(4, r_op(3'b000, 7'h00, 4, 2, 1));
    put_commit(4, 4, 32'd12);
    put_instr(4, jal(5, 8));
    put_commit(4, 5, 32'd24);
    put_instr(4, addi(6, 0, 99));
    put_instr(4, addi(7, 5, 1));
    put_commit(4, 7, 32'd25);
    put_instr(4, jal(0, 0));
  endtask

  task automatic check_equal(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s is %h, expected %h", $time, name, got, exp);
      test_errors++;
    end
  endtask

  // one cycle; commit is stable at the falling edge
  task automatic tick();
    @(negedge clk);
    if (commit.valid === 1'b1) begin
      if (!started) begin
        $display("test %0d: commit to x%0d before start at %0t", cur, commit.rd, $time);
        test_errors++;
      end else if (got_count < exp_len[cur]) begin
        check_equal($sformatf("commit[%0d].rd", got_count), 32'(commit.rd),
                    32'(exp_rd[cur][got_count]));
        check_equal($sformatf("commit[%0d].data", got_count), commit.data,
                    exp_data[cur][got_count]);
        got_count++;
      end else begin
        $display("test %0d: unexpected commit to x%0d at %0t", cur, commit.rd, $time);
        test_errors++;
      end
    end
  endtask

  task automatic run_test(input int t);
    int waited;
    cur         = t;
    got_count   = 0;
    test_errors = 0;
    started     = 1'b0;
    rst         = 1'b1;
    repeat (16) tick();
    rst = 1'b0;
    for (int i = 0; i < prog_len[t]; i++) begin
      tick();
      load_valid = 1'b1;
      load_addr  = IMEM_AW'(i);
      load_data  = prog[t][i];
    end
    tick();
    load_valid = 1'b0;
    start      = 1'b1;
    started    = 1'b1;
    tick();
    start  = 1'b0;
    waited = 0;
    while (got_count < exp_len[t] && waited < 100) begin
      tick();
      waited++;
    end
    if (got_count < exp_len[t]) begin
      $display("test %0d: only %0d of %0d commits arrived", t, got_count, exp_len[t]);
      test_errors++;
    end
    repeat (20) tick(); // idle after the self-jump
    $display("test %0d %s: %0d commits, %0d errors", t, test_errors == 0 ? "ok" : "failed",
             got_count, test_errors);
    total_errors += test_errors;
    if (test_errors != 0) begin
      failed_tests++;
    end
  endtask

  initial begin
    rst          = 1'b1;
    start        = 1'b0;
    load_valid   = 1'b0;
    load_addr    = '0;
    load_data    = '0;
    cycles       = 0;
    started      = 1'b0;
    total_errors = 0;
    failed_tests = 0;
    build_table();
    for (int t = 0; t < N_TESTS; t++) begin
      run_test(t);
    end
    $display("tests %0d, failed %0d, errors %0d", N_TESTS, failed_tests, total_errors);
    if (total_errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule
